//--- build.f
src/decode_pkg.sv
src/instr_queue.sv
src/control_unit.sv
src/reg_file.sv
src/decode_stage.sv
src/decode_top.sv
verif/decode_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  -f build.f --top-module decode_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vdecode_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
  exit 0
fi
exit 1

//--- verif/decode_tb.sv
// ----------------------------------------------------------
// Testbench for the decode top level
// LFSR stimulus, reference decode model, expected queue
// Concurrent checks, per-test report, watchdog
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module decode_tb;
  import decode_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int N_ARITH     = 40;
  localparam int N_MIX       = 40;
  localparam int N_ILL       = 12;
  // Rough cycle budget of all tests
  localparam int STIM_CYCLES = 3 * (N_ARITH + N_MIX + N_ILL) + 300;

  logic       CLK;
  logic       nRST;
  logic       fetch_strobe;
  fetch_pkt_t fetch_pkt;
  logic       wb_strobe;
  wb_pkt_t    wb_pkt;
  logic       hold;
  logic       flush;
  logic       flush_done;
  logic       cache_flush;
  dec_pkt_t   ex_pkt;

  // Model state
  word_t       model_regs [32];
  dec_pkt_t    exp_mem [64];
  dec_pkt_t    exp_head;
  int          exp_rd;
  int          exp_wr;
  logic        flushed_q;
  logic [31:0] lfsr;
  word_t       pc_next;
  string       cur_test;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_err0;
  int          pulses;
  logic        lat_check;
  logic        fence_push;
  logic        in_fence;

  decode_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) decode_top_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .fetch_strobe (fetch_strobe),
    .fetch_pkt    (fetch_pkt),
    .wb_strobe    (wb_strobe),
    .wb_pkt       (wb_pkt),
    .hold         (hold),
    .flush        (flush),
    .flush_done   (flush_done),
    .cache_flush  (cache_flush),
    .ex_pkt       (ex_pkt)
  );

  always #5 CLK = !CLK;

  assign exp_head = exp_mem[exp_rd % 64];

  // Head of expected stream advances once a valid packet was seen
  always @(posedge CLK) flushed_q <= flush;
  always @(negedge CLK) begin
    if (flushed_q)
      exp_rd <= exp_wr;
    else if (ex_pkt.valid)
      exp_rd <= exp_rd + 1;
  end

  always @(posedge CLK) begin
    if (cache_flush)
      pulses <= pulses + 1;
  end

  a_pkt_match: assert property (@(negedge CLK) disable iff (!nRST)
    ex_pkt.valid && (exp_rd != exp_wr) |-> ex_pkt == exp_head)
    else begin
      errors++;
      $display("mismatch %s: expected %h actual %h", cur_test, $sampled(exp_head),
        $sampled(ex_pkt));
    end

  a_no_extra: assert property (@(negedge CLK) disable iff (!nRST)
    ex_pkt.valid |-> exp_rd != exp_wr)
    else begin
      errors++;
      $display("error %s: valid packet with nothing expected", cur_test);
    end

  a_hold_bubble: assert property (@(posedge CLK) disable iff (!nRST)
    (hold || flush) |=> !ex_pkt.valid)
    else begin
      errors++;
      $display("error %s: valid packet after hold or flush", cur_test);
    end

  // Empty queue, strobe at edge k gives valid after k+1
  a_latency: assert property (@(posedge CLK) disable iff (!nRST)
    (fetch_strobe && lat_check) |-> ##2 ex_pkt.valid)
    else begin
      errors++;
      $display("error %s: packet not valid one cycle after push", cur_test);
    end

  a_fence_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    (fetch_strobe && fence_push) |-> ##2 cache_flush)
    else begin
      errors++;
      $display("error %s: no cache flush the cycle after the fence pop", cur_test);
    end

  a_fence_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    in_fence |-> !ex_pkt.valid)
    else begin
      errors++;
      $display("error %s: instruction issued before flush_done", cur_test);
    end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Expected packet straight from the RV32I encoding
  function automatic dec_pkt_t ref_decode(input word_t pc, input word_t ins);
    dec_pkt_t   p;
    logic [2:0] f3;
    logic       shift;
    word_t      r1;
    word_t      r2;
    word_t      i_imm;
    word_t      u_imm;
    f3     = ins[14:12];
    shift  = (f3 == 3'd1) || (f3 == 3'd5);
    r1     = model_regs[ins[19:15]];
    r2     = model_regs[ins[24:20]];
    i_imm  = {{20{ins[31]}}, ins[31:20]};
    u_imm  = {ins[31:12], 12'h000};
    p          = '0;
    p.valid    = 1'b1;
    p.fu_type  = FU_NONE;
    p.alu_op   = ALU_ADD;
    p.pc       = pc;
    p.pc4      = pc + 32'd4;
    p.rd       = ins[11:7];
    p.port_a   = r1;
    p.port_b   = r1;
    p.j_base   = r1;
    p.j_offset = i_imm;
    case (ins[6:0])
      7'h37: begin
        p.fu_type = FU_ARITH;
        p.wen     = 1'b1;
        p.port_a  = '0;
        p.port_b  = u_imm;
        p.wdata   = u_imm;
      end
      7'h17: begin
        p.fu_type = FU_ARITH;
        p.wen     = 1'b1;
        p.port_a  = pc;
        p.port_b  = u_imm;
      end
      7'h6f: begin
        p.fu_type  = FU_BRANCH;
        p.wen      = 1'b1;
        p.jump     = 1'b1;
        p.wdata    = pc + 32'd4;
        p.j_base   = pc;
        p.j_offset = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'h67: begin
        p.fu_type = FU_BRANCH;
        p.wen     = 1'b1;
        p.jump    = 1'b1;
        p.wdata   = pc + 32'd4;
      end
      7'h63: begin
        p.fu_type     = FU_BRANCH;
        p.branch      = 1'b1;
        p.branch_type = f3;
        p.port_b      = r2;
        p.j_base      = pc;
        p.j_offset    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'h03: begin
        p.fu_type = FU_LDST;
        p.load    = 1'b1;
        p.wen     = 1'b1;
        p.port_b  = i_imm;
      end
      7'h23: begin
        p.fu_type = FU_LDST;
        p.store   = 1'b1;
        p.port_a  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      end
      7'h13: begin
        p.fu_type = FU_ARITH;
        p.wen     = 1'b1;
        p.port_b  = shift ? {27'd0, ins[24:20]} : i_imm;
        p.alu_op  = ref_alu(f3, shift && ins[30]);
      end
      7'h33: begin
        p.fu_type = FU_ARITH;
        p.wen     = 1'b1;
        p.port_b  = r2;
        p.alu_op  = ref_alu(f3, ins[30]);
      end
      default: p.illegal = 1'b1;
    endcase
    return p;
  endfunction

  task automatic write_reg(input reg_addr_t rd, input word_t data);
    wb_strobe   = 1'b1;
    wb_pkt.rd   = rd;
    wb_pkt.data = data;
    if (rd != '0)
      model_regs[rd] = data;
    @(negedge CLK);
    wb_strobe = 1'b0;
  endtask

  // One fetch strobe, expected packet queued unless a fence
  task automatic push_instr(input word_t ins, input logic expect_out);
    fetch_strobe    = 1'b1;
    fetch_pkt.pc    = pc_next;
    fetch_pkt.instr = ins;
    if (expect_out) begin
      exp_mem[exp_wr % 64] = ref_decode(pc_next, ins);
      exp_wr++;
    end
    pc_next += 32'd4;
    @(negedge CLK);
    fetch_strobe = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_rd != exp_wr && n < 60) begin
      @(negedge CLK);
      n++;
    end
    if (exp_rd != exp_wr) begin
      errors++;
      $display("error %s: expected packets never came out", cur_test);
    end
    repeat (2) @(negedge CLK);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_err0)
      tests_failed++;
    $display("test %s: %0d errors", cur_test, errors - test_err0);
  endtask

  function automatic word_t gen_arith();
    logic [2:0] f3;
    logic       alt;
    word_t      ins;
    f3  = 3'(rand_bits(3));
    alt = 1'(rand_bits(1));
    if (rand_bits(1) != '0) begin
      // R-type, alternate form only for SUB and SRA
      alt = alt && (f3 == 3'd0 || f3 == 3'd5);
      ins = {alt ? 7'h20 : 7'h00, 10'(rand_bits(10)), f3, 5'(rand_bits(5)), 7'h33};
    end else if (f3 == 3'd1 || f3 == 3'd5) begin
      alt = alt && (f3 == 3'd5);
      ins = {alt ? 7'h20 : 7'h00, 10'(rand_bits(10)), f3, 5'(rand_bits(5)), 7'h13};
    end else begin
      ins = {17'(rand_bits(17)), f3, 5'(rand_bits(5)), 7'h13};
    end
    return ins;
  endfunction

  function automatic word_t gen_mixed();
    logic [6:0] ops [7];
    int         k;
    ops = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h03, 7'h23, 7'h63};
    k   = rand_bits(3) % 7;
    if (ops[k] == 7'h67)
      return {17'(rand_bits(17)), 3'b000, 5'(rand_bits(5)), ops[k]};
    return {25'(rand_bits(25)), ops[k]};
  endfunction

  function automatic word_t gen_illegal();
    logic [6:0] op;
    op = 7'(rand_bits(7));
    while (op inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13,
                      7'h33, 7'h0f})
      op = 7'(rand_bits(7));
    return {25'(rand_bits(25)), op};
  endfunction

  initial begin
    #(STIM_CYCLES * 4 * 10);
    $display("timeout: run did not finish in time");
    $display("Something failed");
    $finish;
  end

  initial begin
    int p0;
    CLK          = 1'b0;
    nRST         = 1'b0;
    fetch_strobe = 1'b0;
    fetch_pkt    = '0;
    wb_strobe    = 1'b0;
    wb_pkt       = '0;
    hold         = 1'b0;
    flush        = 1'b0;
    flush_done   = 1'b0;
    lat_check    = 1'b0;
    fence_push   = 1'b0;
    in_fence     = 1'b0;
    exp_rd       = 0;
    exp_wr       = 0;
    pulses       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr         = 32'h85763bb6;
    pc_next      = 32'h0000_1000;
    cur_test     = "reset";
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    repeat (3) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);

    start_test("arith");
    for (int i = 0; i < 12; i++)
      write_reg(5'(rand_bits(5)), rand_bits(32));
    for (int i = 0; i < N_ARITH; i++)
      push_instr(gen_arith(), 1'b1);
    drain();
    end_test();

    start_test("imm_jump");
    for (int i = 0; i < 8; i++)
      write_reg(5'(rand_bits(5)), rand_bits(32));
    for (int i = 0; i < N_MIX; i++)
      push_instr(gen_mixed(), 1'b1);
    drain();
    end_test();

    start_test("order_latency");
    lat_check = 1'b1;
    push_instr(gen_arith(), 1'b1);
    lat_check = 1'b0;
    drain();
    hold = 1'b1;
    for (int i = 0; i < QUEUE_DEPTH; i++)
      push_instr(gen_mixed(), 1'b1);
    hold = 1'b0;
    drain();
    end_test();

    start_test("hold_flush");
    hold = 1'b1;
    for (int i = 0; i < QUEUE_DEPTH; i++)
      push_instr(gen_arith(), 1'b1);
    repeat (5) @(negedge CLK);
    hold = 1'b0;
    drain();
    hold = 1'b1;
    for (int i = 0; i < 3; i++)
      push_instr(gen_arith(), 1'b1);
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    hold  = 1'b0;
    @(negedge CLK);
    push_instr(gen_mixed(), 1'b1);
    drain();
    end_test();

    start_test("fence_i");
    p0         = pulses;
    fence_push = 1'b1;
    push_instr(32'h0000_100f, 1'b0);
    fence_push = 1'b0;
    push_instr(gen_arith(), 1'b1);
    for (int i = 0; i < 10 && !cache_flush; i++)
      @(negedge CLK);
    in_fence = 1'b1;
    repeat (4) @(negedge CLK);
    flush_done = 1'b1;
    in_fence   = 1'b0;
    @(negedge CLK);
    flush_done = 1'b0;
    drain();
    if (pulses - p0 != 1) begin
      errors++;
      $display("error %s: saw %0d cache flush pulses instead of one", cur_test,
        pulses - p0);
    end
    end_test();

    start_test("illegal");
    for (int i = 0; i < N_ILL; i++)
      push_instr(gen_illegal(), 1'b1);
    drain();
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/decode_top.sv
// ----------------------------------------------------------
// Decode top level
// Queue, control decoder, register file and decode stage
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module decode_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   fetch_strobe,
  input  decode_pkg::fetch_pkt_t fetch_pkt,
  input  logic                   wb_strobe,
  input  decode_pkg::wb_pkt_t    wb_pkt,
  input  logic                   hold,
  input  logic                   flush,
  input  logic                   flush_done,
  output logic                   cache_flush,
  output decode_pkg::dec_pkt_t   ex_pkt
);
  import decode_pkg::*;

  fetch_pkt_t head;
  logic       head_valid;
  logic       pop;
  ctrl_t      ctrl;
  word_t      rs1_data;
  word_t      rs2_data;

  // Fetch side buffer
  instr_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) instr_queue_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .push       (fetch_strobe),
    .push_pkt   (fetch_pkt),
    .pop        (pop),
    .flush      (flush),
    .head       (head),
    .head_valid (head_valid)
  );

  // Decoder works on the queue head
  control_unit control_unit_i (
    .instr (head.instr),
    .ctrl  (ctrl)
  );

  reg_file reg_file_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .wen      (wb_strobe),
    .wb       (wb_pkt),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  decode_stage decode_stage_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .head        (head),
    .head_valid  (head_valid),
    .ctrl        (ctrl),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .hold        (hold),
    .flush       (flush),
    .flush_done  (flush_done),
    .pop         (pop),
    .cache_flush (cache_flush),
    .ex_pkt      (ex_pkt)
  );

endmodule

`default_nettype wire

//--- src/decode_stage.sv
// ----------------------------------------------------------
// Decode stage toward execute
// Immediate extension, operand select, jump base/offset
// FENCE.I flush sequencing, registered execute packet
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
  input  logic                   CLK,
  input  logic                   nRST,
  input  decode_pkg::fetch_pkt_t head,
  input  logic                   head_valid,
  input  decode_pkg::ctrl_t      ctrl,
  input  decode_pkg::word_t      rs1_data,
  input  decode_pkg::word_t      rs2_data,
  input  logic                   hold,
  input  logic                   flush,
  input  logic                   flush_done,
  output logic                   pop,
  output logic                   cache_flush,
  output decode_pkg::dec_pkt_t   ex_pkt
);
  import decode_pkg::*;

  typedef enum logic [1:0] {
    FENCE_IDLE,
    FENCE_PULSE,
    FENCE_WAIT
  } fence_state_e;

  fence_state_e fence_state;
  fence_state_e fence_next;
  word_t        imm_I_ext;
  word_t        imm_S_ext;
  word_t        imm_SB_ext;
  word_t        imm_U_ext;
  word_t        imm_UJ_ext;
  word_t        imm_or_shamt;
  word_t        pc4;
  dec_pkt_t     issue_pkt;

  // Sign extension
  assign imm_I_ext  = {{20{ctrl.imm_I[11]}}, ctrl.imm_I};
  assign imm_S_ext  = {{20{ctrl.imm_S[11]}}, ctrl.imm_S};
  assign imm_SB_ext = {{19{ctrl.imm_SB[12]}}, ctrl.imm_SB};
  assign imm_U_ext  = {ctrl.imm_U, 12'h000};
  assign imm_UJ_ext = {{11{ctrl.imm_UJ[20]}}, ctrl.imm_UJ};
  // Shamt is the low five bits of the I field
  assign imm_or_shamt = ctrl.imm_shamt_sel ? {27'd0, ctrl.imm_I[4:0]} : imm_I_ext;
  assign pc4 = head.pc + 32'd4;

  // Pop only when nothing blocks the head
  assign pop = head_valid && !hold && !flush && (fence_state == FENCE_IDLE);

  always_comb begin
    fence_next = fence_state;
    if (flush) begin
      fence_next = FENCE_IDLE;
    end else begin
      case (fence_state)
        FENCE_IDLE:  if (pop && ctrl.ifence) fence_next = FENCE_PULSE;
        FENCE_PULSE: fence_next = FENCE_WAIT;
        FENCE_WAIT:  if (flush_done) fence_next = FENCE_IDLE;
        default:     fence_next = FENCE_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      fence_state <= FENCE_IDLE;
    else
      fence_state <= fence_next;
  end

  // Flush request lasts the single PULSE cycle
  assign cache_flush = (fence_state == FENCE_PULSE);

  always_comb begin
    issue_pkt             = '0;
    issue_pkt.valid       = 1'b1;
    issue_pkt.fu_type     = ctrl.fu_type;
    issue_pkt.alu_op      = ctrl.alu_op;
    issue_pkt.pc          = head.pc;
    issue_pkt.pc4         = pc4;
    issue_pkt.rd          = ctrl.rd;
    issue_pkt.wen         = ctrl.wen;
    issue_pkt.jump        = ctrl.jump;
    issue_pkt.branch      = ctrl.branch;
    issue_pkt.branch_type = ctrl.branch_type;
    issue_pkt.load        = ctrl.load;
    issue_pkt.store       = ctrl.store;
    issue_pkt.illegal     = ctrl.illegal;
    case (ctrl.src_a_sel)
      2'd0:    issue_pkt.port_a = rs1_data;
      2'd1:    issue_pkt.port_a = imm_S_ext;
      2'd2:    issue_pkt.port_a = head.pc;
      default: issue_pkt.port_a = '0;
    endcase
    case (ctrl.src_b_sel)
      2'd0:    issue_pkt.port_b = rs1_data;
      2'd1:    issue_pkt.port_b = rs2_data;
      2'd2:    issue_pkt.port_b = imm_or_shamt;
      default: issue_pkt.port_b = imm_U_ext;
    endcase
    // Link value for jumps, upper immediate for LUI
    case (ctrl.w_src)
      2'd1:    issue_pkt.wdata = pc4;
      2'd2:    issue_pkt.wdata = imm_U_ext;
      default: issue_pkt.wdata = '0;
    endcase
    // pc relative for JAL and branches, rs1 relative for JALR
    if (ctrl.j_sel) begin
      issue_pkt.j_base   = head.pc;
      issue_pkt.j_offset = ctrl.branch ? imm_SB_ext : imm_UJ_ext;
    end else begin
      issue_pkt.j_base   = rs1_data;
      issue_pkt.j_offset = imm_I_ext;
    end
  end

  // A popped FENCE.I leaves a bubble behind
  // Bubble is all zero, which reads as FU_NONE
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      ex_pkt <= '0;
    else if (pop && !ctrl.ifence)
      ex_pkt <= issue_pkt;
    else
      ex_pkt <= '0;
  end

  a_flush_single: assert property (@(posedge CLK) disable iff (!nRST)
    cache_flush |=> !cache_flush)
    else $error("decode_stage: cache_flush held two cycles");

endmodule

`default_nettype wire

//--- src/reg_file.sv
// ----------------------------------------------------------
// Integer register file, two read ports, one write port
// x0 reads zero, same-cycle writes forward to the reads
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module reg_file (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  wen,
  input  decode_pkg::wb_pkt_t   wb,
  input  decode_pkg::reg_addr_t rs1,
  input  decode_pkg::reg_addr_t rs2,
  output decode_pkg::word_t     rs1_data,
  output decode_pkg::word_t     rs2_data
);
  import decode_pkg::*;

  // Entry 0 is cleared by reset and never written
  word_t regs [32];
  logic  write_hit;

  assign write_hit = wen && (wb.rd != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (write_hit) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Forward the value being written this cycle
  assign rs1_data = (write_hit && (wb.rd == rs1)) ? wb.data : regs[rs1];
  assign rs2_data = (write_hit && (wb.rd == rs2)) ? wb.data : regs[rs2];

endmodule

`default_nettype wire

//--- src/control_unit.sv
// ----------------------------------------------------------
// RV32I control decoder
// Opcode/funct decode into unit, ALU op and selects
// Raw immediate slicing, illegal encoding detection
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module control_unit (
  input  decode_pkg::word_t instr,
  output decode_pkg::ctrl_t ctrl
);
  import decode_pkg::*;

  // Major opcodes
  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_AUIPC    = 7'b0010111;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_LOAD     = 7'b0000011;
  localparam logic [6:0] OP_STORE    = 7'b0100011;
  localparam logic [6:0] OP_IMM      = 7'b0010011;
  localparam logic [6:0] OP_REG      = 7'b0110011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;

  logic [6:0] opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  logic       funct7_ok;
  logic       is_shift;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  // Only base and alternate encodings exist
  assign funct7_ok = (funct7 == 7'h00) || (funct7 == 7'h20);
  assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);

  // funct3 to ALU op, alt is instr[30] where it matters
  function automatic alu_op_e alu_from_funct3(input funct3_t f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl         = '0;
    ctrl.fu_type = FU_NONE;
    ctrl.alu_op  = ALU_ADD;
    ctrl.rs1     = instr[19:15];
    ctrl.rs2     = instr[24:20];
    ctrl.rd      = instr[11:7];
    // Raw immediate fields, extension happens in decode
    ctrl.imm_I   = instr[31:20];
    ctrl.imm_S   = {instr[31:25], instr[11:7]};
    ctrl.imm_SB  = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_U   = instr[31:12];
    ctrl.imm_UJ  = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    case (opcode)
      OP_LUI: begin
        // Zero plus imm_U, value also ready as wdata
        ctrl.fu_type   = FU_ARITH;
        ctrl.wen       = 1'b1;
        ctrl.src_a_sel = 2'd3;
        ctrl.src_b_sel = 2'd3;
        ctrl.w_src     = 2'd2;
      end
      OP_AUIPC: begin
        ctrl.fu_type   = FU_ARITH;
        ctrl.wen       = 1'b1;
        ctrl.src_a_sel = 2'd2;
        ctrl.src_b_sel = 2'd3;
      end
      OP_JAL: begin
        ctrl.fu_type = FU_BRANCH;
        ctrl.wen     = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.j_sel   = 1'b1;
        ctrl.w_src   = 2'd1;
      end
      OP_JALR: begin
        // Base rs1 and offset imm_I
        ctrl.fu_type = FU_BRANCH;
        ctrl.wen     = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.w_src   = 2'd1;
      end
      OP_BRANCH: begin
        // Compare rs1 with rs2, target is pc relative
        ctrl.fu_type     = FU_BRANCH;
        ctrl.branch      = 1'b1;
        ctrl.j_sel       = 1'b1;
        ctrl.branch_type = funct3;
        ctrl.src_b_sel   = 2'd1;
      end
      OP_LOAD: begin
        ctrl.fu_type   = FU_LDST;
        ctrl.load      = 1'b1;
        ctrl.wen       = 1'b1;
        ctrl.src_b_sel = 2'd2;
      end
      OP_STORE: begin
        // Address operands are imm_S and rs1
        ctrl.fu_type   = FU_LDST;
        ctrl.store     = 1'b1;
        ctrl.src_a_sel = 2'd1;
      end
      OP_IMM: begin
        ctrl.fu_type       = FU_ARITH;
        ctrl.wen           = 1'b1;
        ctrl.src_b_sel     = 2'd2;
        ctrl.imm_shamt_sel = is_shift;
        if (is_shift) begin
          ctrl.alu_op  = alu_from_funct3(funct3, instr[30]);
          ctrl.illegal = !funct7_ok;
        end else begin
          ctrl.alu_op = alu_from_funct3(funct3, 1'b0);
        end
      end
      OP_REG: begin
        ctrl.fu_type   = FU_ARITH;
        ctrl.wen       = 1'b1;
        ctrl.src_b_sel = 2'd1;
        ctrl.alu_op    = alu_from_funct3(funct3, instr[30]);
        ctrl.illegal   = !funct7_ok;
      end
      OP_MISC_MEM: begin
        // FENCE is a no-op here, FENCE.I flushes the caches
        if (funct3 == 3'b001)
          ctrl.ifence = 1'b1;
        else if (funct3 != 3'b000)
          ctrl.illegal = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // Illegal encodings carry no side effects
    if (ctrl.illegal) begin
      ctrl.fu_type = FU_NONE;
      ctrl.wen     = 1'b0;
      ctrl.jump    = 1'b0;
      ctrl.branch  = 1'b0;
      ctrl.load    = 1'b0;
      ctrl.store   = 1'b0;
      ctrl.ifence  = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/instr_queue.sv
// ----------------------------------------------------------
// Instruction queue between fetch and decode
// Circular buffer of fetch packets, flush clears it
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module instr_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   push,
  input  decode_pkg::fetch_pkt_t push_pkt,
  input  logic                   pop,
  input  logic                   flush,
  output decode_pkg::fetch_pkt_t head,
  output logic                   head_valid
);
  import decode_pkg::*;

  // Depth must be a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  fetch_pkt_t       mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full       = (count == (PTR_W+1)'(QUEUE_DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // Flush wins over a push or pop on the same edge
  assign do_push = push && !full && !flush;
  assign do_pop  = pop && head_valid && !flush;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Occupancy only moves when exactly one side is active
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (!do_push && do_pop)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (do_push)
      mem[wr_ptr] <= push_pkt;
  end

  // Fetch has no back-pressure, it must respect the depth
  a_no_push_full: assert property (@(posedge CLK) disable iff (!nRST)
    push |-> !full)
    else $error("instr_queue: push while full");

  // Decode may only pop a valid head
  a_no_pop_empty: assert property (@(posedge CLK) disable iff (!nRST)
    pop |-> head_valid)
    else $error("instr_queue: pop while empty");

endmodule

`default_nettype wire

//--- src/decode_pkg.sv
// ----------------------------------------------------------
// Shared types for the RV32I decode slice
// Word and register index types, fetch and write-back packets
// Unit and ALU encodings, decoder fields, execute packet
// ----------------------------------------------------------
`default_nettype none

package decode_pkg;

  // Architectural widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  funct3_t;

  // One fetched instruction with its address
  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_pkt_t;

  // FU_NONE at zero so an all-zero packet reads as a bubble
  typedef enum logic [1:0] {
    FU_NONE   = 2'd0,
    FU_ARITH  = 2'd1,
    FU_LDST   = 2'd2,
    FU_BRANCH = 2'd3
  } fu_type_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Decoder output, immediates still raw
  typedef struct packed {
    fu_type_e    fu_type;
    alu_op_e     alu_op;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic        wen;
    logic [1:0]  src_a_sel;
    logic [1:0]  src_b_sel;
    logic [1:0]  w_src;
    logic        imm_shamt_sel;
    logic [11:0] imm_I;
    logic [11:0] imm_S;
    logic [12:0] imm_SB;
    logic [19:0] imm_U;
    logic [20:0] imm_UJ;
    logic        j_sel;
    logic        jump;
    logic        branch;
    funct3_t     branch_type;
    logic        load;
    logic        store;
    logic        ifence;
    logic        illegal;
  } ctrl_t;

  // Registered decode result toward execute
  typedef struct packed {
    logic      valid;
    fu_type_e  fu_type;
    alu_op_e   alu_op;
    word_t     pc;
    word_t     pc4;
    word_t     port_a;
    word_t     port_b;
    reg_addr_t rd;
    logic      wen;
    word_t     wdata;
    word_t     j_base;
    word_t     j_offset;
    logic      jump;
    logic      branch;
    funct3_t   branch_type;
    logic      load;
    logic      store;
    logic      illegal;
  } dec_pkt_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
  } wb_pkt_t;

endpackage

`default_nettype wire
